/* files.f */
+incdir+src
src/memctl_pkg.sv
src/slot_if.sv
src/snes_bus_sync.sv
src/slot_sequencer.sv
src/address_map.sv
src/data_path.sv
src/memctl_top.sv
testbench/memctl_assert.sv
testbench/tb_memctl.sv

/* src/address_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memctl_macros.svh"

module address_map (
  input  memctl_pkg::snes_addr_t snes_addr,
  input  memctl_pkg::snes_addr_t mcu_addr,
  input  memctl_pkg::mapper_e    mapper,
  input  memctl_pkg::snes_addr_t rom_mask,
  input  memctl_pkg::snes_addr_t saveram_mask,
  input  wire                    mode,
  input  wire                    snes_cs,
  input  wire                    snes_read,
  input  wire                    snes_write,
  input  wire                    rom_we_slot,
  output memctl_pkg::rom_addr_t  rom_addr,
  output logic                   rom_addr0,
  output logic                   rom_we,
  output logic                   snes_databus_oe,
  output logic                   snes_databus_dir
);

  logic is_rom;
  logic is_saveram;
  logic snes_access;

  memctl_pkg::snes_addr_t rom_byte;
  memctl_pkg::snes_addr_t ram_byte;
  memctl_pkg::snes_addr_t byte_addr;

  ////////////////////////////////////////
  // Mapper decode
  ////////////////////////////////////////

  always_comb begin
    if (mapper == memctl_pkg::HIROM) begin
      is_rom     = snes_addr[22] | snes_addr[15];
      is_saveram = (snes_addr[22:21] == 2'b01) && (snes_addr[15:13] == 3'b011);
      rom_byte   = {2'b00, snes_addr[21:0]} & rom_mask;
      ram_byte   = `MEMCTL_SAVERAM_BASE
                 + ({6'd0, snes_addr[20:16], snes_addr[12:0]} & saveram_mask);
    end else begin
      // LoROM: upper half of each bank, save RAM in banks 70 to 7D
      is_rom     = snes_addr[15];
      is_saveram = (snes_addr[22:20] == 3'b111) && (snes_addr[19:16] < 4'hE)
                 && !snes_addr[15];
      rom_byte   = {2'b00, snes_addr[22:16], snes_addr[14:0]} & rom_mask;
      ram_byte   = `MEMCTL_SAVERAM_BASE
                 + ({5'd0, snes_addr[19:16], snes_addr[14:0]} & saveram_mask);
    end
  end

  ////////////////////////////////////////
  // Address mux
  ////////////////////////////////////////

  // MCU addresses go through untranslated
  assign byte_addr = mode ? mcu_addr : (is_saveram ? ram_byte : rom_byte);

  assign rom_addr  = byte_addr[`MEMCTL_ROM_AW:1];
  assign rom_addr0 = byte_addr[0];

  // Only save RAM is writable from the console
  assign rom_we = rom_we_slot | (!mode & !is_saveram);

  ////////////////////////////////////////
  // Console data bus buffer
  ////////////////////////////////////////

  assign snes_access = !snes_read | !snes_write;

  assign snes_databus_oe  = !(snes_access & (is_saveram | (is_rom & !snes_cs)));
  assign snes_databus_dir = !snes_read;

endmodule

`default_nettype wire

/* src/data_path.sv */
`timescale 1ns/1ps
`default_nettype none

module data_path (
  input  wire                clk2,
  input  wire                rst_n,
  slot_if.dp                 bus,
  input  wire                rom_addr0,
  input  wire                rom_we,
  input  memctl_pkg::byte_t  snes_data_in,
  input  memctl_pkg::byte_t  mcu_data_in,
  input  memctl_pkg::word_t  rom_data_in,
  output memctl_pkg::byte_t  snes_data_out,
  output memctl_pkg::byte_t  mcu_data_out,
  output memctl_pkg::word_t  rom_data_out,
  output logic               rom_data_oe,
  output logic               rom_bhe,
  output logic               rom_ble
);

  memctl_pkg::byte_t rom_lane;
  memctl_pkg::byte_t snes_wr_byte;
  memctl_pkg::byte_t mcu_wr_byte;
  memctl_pkg::byte_t wr_byte;

  ////////////////////////////////////////
  // Read latches
  ////////////////////////////////////////

  // Odd byte sits in the low lane
  assign rom_lane = rom_addr0 ? rom_data_in[7:0] : rom_data_in[15:8];

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      snes_data_out <= '0;
      mcu_data_out  <= '0;
    end else begin
      if (bus.rom_to_snes) begin
        snes_data_out <= rom_lane;
      end
      if (bus.rom_to_mcu) begin
        mcu_data_out <= rom_lane;
      end
    end
  end

  ////////////////////////////////////////
  // Write latches
  ////////////////////////////////////////

  always_ff @(posedge clk2) begin
    if (bus.snes_to_mem) begin
      snes_wr_byte <= snes_data_in;
    end
    if (bus.mcu_to_mem) begin
      mcu_wr_byte <= mcu_data_in;
    end
  end

  // MCU byte passes straight through while its write is on
  always_comb begin
    if (bus.mode) begin
      wr_byte = bus.mcu_to_mem ? mcu_data_in : mcu_wr_byte;
    end else begin
      wr_byte = snes_wr_byte;
    end
  end

  assign rom_data_out = {wr_byte, wr_byte};
  assign rom_data_oe  = !rom_we;

  ////////////////////////////////////////
  // Byte lanes
  ////////////////////////////////////////

  // Both lanes enabled for reads
  assign rom_bhe = !rom_we ? rom_addr0 : 1'b0;
  assign rom_ble = !rom_we ? !rom_addr0 : 1'b0;

endmodule

`default_nettype wire

/* src/memctl_macros.svh */
`ifndef MEMCTL_MACROS_SVH
`define MEMCTL_MACROS_SVH

////////////////////////////////////////
// Address widths
////////////////////////////////////////

// Console and MCU byte address
`define MEMCTL_SNES_AW 24

// PSRAM word address
`define MEMCTL_ROM_AW 23

////////////////////////////////////////
// Slot schedule
////////////////////////////////////////

// Active slots per console cycle
`define MEMCTL_SLOTS 13

// Slots 0 to this one belong to the console
`define MEMCTL_SNES_LAST 5

// Data strobe slots
`define MEMCTL_STRB_SNES_WR 3
`define MEMCTL_STRB_SNES_RD 4
`define MEMCTL_STRB_MCU_RD 12

// Save RAM region in the PSRAM byte space
`define MEMCTL_SAVERAM_BASE 24'hE00000

// CPU clock low samples before a cycle may start
`define MEMCTL_CPUCLK_LOW 4

`endif

/* src/memctl_pkg.sv */
`default_nettype none

`include "memctl_macros.svh"

package memctl_pkg;

  ////////////////////////////////////////
  // Address and data types
  ////////////////////////////////////////

  // Byte address as seen by the console or the MCU
  typedef logic [`MEMCTL_SNES_AW-1:0] snes_addr_t;

  // Word address on the PSRAM pins
  typedef logic [`MEMCTL_ROM_AW-1:0] rom_addr_t;

  typedef logic [7:0] byte_t;

  // One PSRAM data word, two byte lanes
  typedef logic [15:0] word_t;

  ////////////////////////////////////////
  // Enumerations
  ////////////////////////////////////////

  typedef enum logic {
    LOROM = 1'b0,
    HIROM = 1'b1
  } mapper_e;

  // One state per slot, idle after the last one
  typedef enum logic [3:0] {
    SLOT_0    = 4'd0,
    SLOT_1    = 4'd1,
    SLOT_2    = 4'd2,
    SLOT_3    = 4'd3,
    SLOT_4    = 4'd4,
    SLOT_5    = 4'd5,
    SLOT_6    = 4'd6,
    SLOT_7    = 4'd7,
    SLOT_8    = 4'd8,
    SLOT_9    = 4'd9,
    SLOT_10   = 4'd10,
    SLOT_11   = 4'd11,
    SLOT_12   = 4'd12,
    SLOT_IDLE = 4'd13
  } slot_e;

endpackage

`default_nettype wire

/* src/memctl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module memctl_top (
  input  wire                    clk2,
  input  wire                    rst_n,
  // Console bus
  input  memctl_pkg::snes_addr_t snes_addr,
  input  wire                    snes_read,
  input  wire                    snes_write,
  input  wire                    snes_cs,
  input  wire                    snes_cpu_clk,
  input  memctl_pkg::byte_t      snes_data_in,
  output memctl_pkg::byte_t      snes_data_out,
  output logic                   snes_databus_oe,
  output logic                   snes_databus_dir,
  // MCU port
  input  wire                    mcu_ovr,
  input  wire                    mcu_read,
  input  wire                    mcu_write,
  input  memctl_pkg::snes_addr_t mcu_addr,
  input  memctl_pkg::byte_t      mcu_data_in,
  output memctl_pkg::byte_t      mcu_data_out,
  // Mapping setup
  input  memctl_pkg::mapper_e    mapper,
  input  memctl_pkg::snes_addr_t rom_mask,
  input  memctl_pkg::snes_addr_t saveram_mask,
  // PSRAM
  output memctl_pkg::rom_addr_t  rom_addr,
  input  memctl_pkg::word_t      rom_data_in,
  output memctl_pkg::word_t      rom_data_out,
  output logic                   rom_data_oe,
  output logic                   rom_ce,
  output logic                   rom_oe,
  output logic                   rom_we,
  output logic                   rom_bhe,
  output logic                   rom_ble
);

  logic snes_read_s;
  logic snes_write_s;
  logic cycle_start;
  logic rom_addr0;

  slot_if slot_bus ();

  snes_bus_sync i_snes_bus_sync (
    .clk2         (clk2),
    .rst_n        (rst_n),
    .snes_cpu_clk (snes_cpu_clk),
    .snes_read    (snes_read),
    .snes_write   (snes_write),
    .snes_read_s  (snes_read_s),
    .snes_write_s (snes_write_s),
    .cycle_start  (cycle_start)
  );

  slot_sequencer i_slot_sequencer (
    .clk2         (clk2),
    .rst_n        (rst_n),
    .cycle_start  (cycle_start),
    .snes_write_s (snes_write_s),
    .mcu_read     (mcu_read),
    .mcu_write    (mcu_write),
    .mcu_ovr      (mcu_ovr),
    .bus          (slot_bus.seq)
  );

  address_map i_address_map (
    .snes_addr        (snes_addr),
    .mcu_addr         (mcu_addr),
    .mapper           (mapper),
    .rom_mask         (rom_mask),
    .saveram_mask     (saveram_mask),
    .mode             (slot_bus.mode),
    .snes_cs          (snes_cs),
    .snes_read        (snes_read_s),
    .snes_write       (snes_write_s),
    .rom_we_slot      (slot_bus.rom_we),
    .rom_addr         (rom_addr),
    .rom_addr0        (rom_addr0),
    .rom_we           (rom_we),
    .snes_databus_oe  (snes_databus_oe),
    .snes_databus_dir (snes_databus_dir)
  );

  data_path i_data_path (
    .clk2          (clk2),
    .rst_n         (rst_n),
    .bus           (slot_bus.dp),
    .rom_addr0     (rom_addr0),
    .rom_we        (rom_we),
    .snes_data_in  (snes_data_in),
    .mcu_data_in   (mcu_data_in),
    .rom_data_in   (rom_data_in),
    .snes_data_out (snes_data_out),
    .mcu_data_out  (mcu_data_out),
    .rom_data_out  (rom_data_out),
    .rom_data_oe   (rom_data_oe),
    .rom_bhe       (rom_bhe),
    .rom_ble       (rom_ble)
  );

  // Chip stays selected, OE comes straight from the slot tables
  assign rom_ce = 1'b0;
  assign rom_oe = slot_bus.rom_oe;

endmodule

`default_nettype wire

/* src/slot_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface slot_if;

  // 1 while the MCU owns the memory
  logic mode;

  // PSRAM controls from the slot tables, active low
  logic rom_we;
  logic rom_oe;

  // Data latch enables
  logic snes_to_mem;
  logic rom_to_snes;
  logic rom_to_mcu;
  logic mcu_to_mem;

  modport seq (
    output mode, rom_we, rom_oe,
    output snes_to_mem, rom_to_snes, rom_to_mcu, mcu_to_mem
  );

  // Data path only needs the phase and the latch enables
  modport dp (
    input mode,
    input snes_to_mem, rom_to_snes, rom_to_mcu, mcu_to_mem
  );

endinterface

`default_nettype wire

/* src/slot_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memctl_macros.svh"

module slot_sequencer (
  input  wire  clk2,
  input  wire  rst_n,
  input  wire  cycle_start,
  input  wire  snes_write_s,
  input  wire  mcu_read,
  input  wire  mcu_write,
  input  wire  mcu_ovr,
  slot_if.seq  bus
);

  memctl_pkg::slot_e slot_q;
  memctl_pkg::slot_e slot_next;

  // Captured cycle types, 1 = read
  logic snes_wr_n_q;
  logic mcu_wr_n_q;

  logic is_idle;
  logic mcu_phase;
  logic owner_wr_n;
  logic we_tab;
  logic oe_tab;

  ////////////////////////////////////////
  // Slot FSM
  ////////////////////////////////////////

  always_comb begin
    if (slot_q == memctl_pkg::SLOT_IDLE ||
        slot_q >= memctl_pkg::slot_e'(`MEMCTL_SLOTS - 1)) begin
      slot_next = memctl_pkg::SLOT_IDLE;
    end else begin
      slot_next = memctl_pkg::slot_e'(slot_q + 4'd1);
    end
  end

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      slot_q      <= memctl_pkg::SLOT_IDLE;
      snes_wr_n_q <= 1'b1;
      mcu_wr_n_q  <= 1'b1;
    end else begin
      mcu_wr_n_q <= mcu_write;
      if (cycle_start) begin
        slot_q      <= memctl_pkg::SLOT_0;
        snes_wr_n_q <= snes_write_s;
      end else begin
        // Write strobe may arrive a little late, sample again
        if (slot_q == memctl_pkg::SLOT_0) begin
          snes_wr_n_q <= snes_write_s;
        end
        slot_q <= slot_next;
      end
    end
  end

  ////////////////////////////////////////
  // Slot table lookup
  ////////////////////////////////////////

  assign is_idle   = (slot_q == memctl_pkg::SLOT_IDLE);
  assign mcu_phase = !is_idle && (slot_q > memctl_pkg::slot_e'(`MEMCTL_SNES_LAST));

  // Write flag of whoever owns the current slot
  assign owner_wr_n = mcu_phase ? mcu_wr_n_q : snes_wr_n_q;

  // WE low in owned slots of a write, OE low in owned slots of a read
  assign we_tab = is_idle | owner_wr_n;
  assign oe_tab = is_idle ? ~snes_wr_n_q : ~owner_wr_n;

  ////////////////////////////////////////
  // Outputs with MCU override
  ////////////////////////////////////////

  assign bus.mode   = mcu_ovr ? mcu_phase : 1'b1;
  assign bus.rom_we = mcu_ovr ? we_tab : mcu_write;
  assign bus.rom_oe = mcu_ovr ? oe_tab : mcu_read;

  assign bus.snes_to_mem = (slot_q == memctl_pkg::slot_e'(`MEMCTL_STRB_SNES_WR)) & ~snes_wr_n_q;
  assign bus.rom_to_snes = (slot_q == memctl_pkg::slot_e'(`MEMCTL_STRB_SNES_RD)) & snes_wr_n_q;
  assign bus.rom_to_mcu  = (slot_q == memctl_pkg::slot_e'(`MEMCTL_STRB_MCU_RD)) & mcu_wr_n_q;

  // Follows the pin directly under override so data keeps up with WE
  assign bus.mcu_to_mem = mcu_ovr ? ~mcu_wr_n_q : ~mcu_write;

endmodule

`default_nettype wire

/* src/snes_bus_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memctl_macros.svh"

module snes_bus_sync (
  input  wire  clk2,
  input  wire  rst_n,
  input  wire  snes_cpu_clk,
  input  wire  snes_read,
  input  wire  snes_write,
  output logic snes_read_s,
  output logic snes_write_s,
  output logic cycle_start
);

  localparam int HIST_W = `MEMCTL_CPUCLK_LOW + 2;

  logic [1:0]        read_sync;
  logic [1:0]        write_sync;
  logic [HIST_W-1:0] cpu_clk_hist;

  ////////////////////////////////////////
  // Strobe synchronizers
  ////////////////////////////////////////

  // Strobes idle high
  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      read_sync  <= 2'b11;
      write_sync <= 2'b11;
    end else begin
      read_sync  <= {read_sync[0], snes_read};
      write_sync <= {write_sync[0], snes_write};
    end
  end

  assign snes_read_s  = read_sync[1];
  assign snes_write_s = write_sync[1];

  ////////////////////////////////////////
  // CPU clock history
  ////////////////////////////////////////

  // Oldest sample in the top bit
  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      cpu_clk_hist <= '1;
    end else begin
      cpu_clk_hist <= {cpu_clk_hist[HIST_W-2:0], snes_cpu_clk};
    end
  end

  // Enough low samples, then two high ones
  assign cycle_start = (cpu_clk_hist == {{`MEMCTL_CPUCLK_LOW{1'b0}}, 2'b11});

endmodule

`default_nettype wire

/* testbench/memctl_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module memctl_assert (
  input wire clk2,
  input wire rst_n,
  input wire mcu_ovr,
  input wire rom_we,
  input wire rom_oe,
  input wire rom_data_oe,
  input wire rom_bhe,
  input wire rom_ble
);

  int unsigned fail_count = 0;

  ////////////////////////////////////////
  // PSRAM control rules
  ////////////////////////////////////////

  // Slot tables never open both WE and OE
  a_we_oe_exclusive : assert property (
    @(posedge clk2) disable iff (!rst_n) mcu_ovr |-> (rom_we || rom_oe)
  ) else begin
    fail_count++;
    $error("rom_we and rom_oe low together in slot mode");
  end

  // Data pins drive exactly while writing
  a_data_oe_tracks_we : assert property (
    @(posedge clk2) disable iff (!rst_n) rom_data_oe == !rom_we
  ) else begin
    fail_count++;
    $error("rom_data_oe does not follow rom_we");
  end

  // Single byte lane per write
  a_one_lane_on_write : assert property (
    @(posedge clk2) disable iff (!rst_n) !rom_we |-> (rom_bhe ^ rom_ble)
  ) else begin
    fail_count++;
    $error("byte lanes not exclusive during a write");
  end

endmodule

bind memctl_top memctl_assert i_memctl_assert (
  .clk2        (clk2),
  .rst_n       (rst_n),
  .mcu_ovr     (mcu_ovr),
  .rom_we      (rom_we),
  .rom_oe      (rom_oe),
  .rom_data_oe (rom_data_oe),
  .rom_bhe     (rom_bhe),
  .rom_ble     (rom_ble)
);

`default_nettype wire

/* testbench/tb_memctl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memctl_macros.svh"

module tb_memctl;

  localparam int CLK_PERIOD = 10;
  localparam int LOOPS      = 4;
  localparam int HIGH_LEN   = 24;
  // Slot 0 is seen three samples after the CPU clock rises
  localparam int SLOT0_IDX  = 3;
  localparam int MCU_IDX    = SLOT0_IDX + `MEMCTL_SNES_LAST + 1;
  localparam int LAST_IDX   = SLOT0_IDX + `MEMCTL_SLOTS - 1;
  // Six tests of four console cycles at 31 clocks, plus margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic                   clk2;
  logic                   rst_n;
  memctl_pkg::snes_addr_t snes_addr;
  logic                   snes_read;
  logic                   snes_write;
  logic                   snes_cs;
  logic                   snes_cpu_clk;
  memctl_pkg::byte_t      snes_data_in;
  memctl_pkg::byte_t      snes_data_out;
  logic                   snes_databus_oe;
  logic                   snes_databus_dir;
  logic                   mcu_ovr;
  logic                   mcu_read;
  logic                   mcu_write;
  memctl_pkg::snes_addr_t mcu_addr;
  memctl_pkg::byte_t      mcu_data_in;
  memctl_pkg::byte_t      mcu_data_out;
  memctl_pkg::mapper_e    mapper;
  memctl_pkg::snes_addr_t rom_mask;
  memctl_pkg::snes_addr_t saveram_mask;
  memctl_pkg::rom_addr_t  rom_addr;
  memctl_pkg::word_t      rom_data_in;
  memctl_pkg::word_t      rom_data_out;
  logic                   rom_data_oe;
  logic                   rom_ce;
  logic                   rom_oe;
  logic                   rom_we;
  logic                   rom_bhe;
  logic                   rom_ble;

  // One sample per clock of the CPU clock high phase
  logic                   we_log   [HIGH_LEN];
  logic                   dboe_log [HIGH_LEN];
  logic                   bhe_log  [HIGH_LEN];
  logic                   ble_log  [HIGH_LEN];
  memctl_pkg::rom_addr_t  addr_log [HIGH_LEN];
  memctl_pkg::word_t      dout_log [HIGH_LEN];

  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int cycle_count  = 0;

  memctl_top i_memctl_top (.*);

  initial begin
    clk2 = 1'b0;
    forever #(CLK_PERIOD / 2) clk2 = ~clk2;
  end

  always @(posedge clk2) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_rom_addr(input string name, input memctl_pkg::rom_addr_t exp,
                                input memctl_pkg::rom_addr_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input memctl_pkg::word_t exp,
                            input memctl_pkg::word_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input memctl_pkg::byte_t exp,
                            input memctl_pkg::byte_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  ////////////////////////////////////////
  // Console cycle with pin logging
  ////////////////////////////////////////

  task automatic cpu_cycle();
    int i;
    @(posedge clk2);
    snes_cpu_clk <= 1'b0;
    repeat (6) @(posedge clk2);
    snes_cpu_clk <= 1'b1;
    for (i = 0; i < HIGH_LEN; i++) begin
      @(negedge clk2);
      we_log[i]   = rom_we;
      dboe_log[i] = snes_databus_oe;
      bhe_log[i]  = rom_bhe;
      ble_log[i]  = rom_ble;
      addr_log[i] = rom_addr;
      dout_log[i] = rom_data_out;
      @(posedge clk2);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_idle();
    int e0;
    e0 = errors;
    @(negedge clk2);
    check_bit("reset_idle rom_we", 1'b1, rom_we);
    check_bit("reset_idle rom_data_oe", 1'b0, rom_data_oe);
    check_bit("reset_idle rom_ce", 1'b0, rom_ce);
    @(posedge clk2);
    snes_read <= 1'b0;
    // Two synchronizer stages plus one
    repeat (3) @(posedge clk2);
    @(negedge clk2);
    check_bit("reset_idle dir read", 1'b1, snes_databus_dir);
    @(posedge clk2);
    snes_read <= 1'b1;
    repeat (3) @(posedge clk2);
    @(negedge clk2);
    check_bit("reset_idle dir idle", 1'b0, snes_databus_dir);
    finish_test("reset_idle", e0);
  endtask

  task automatic lorom_read();
    int e0;
    int n;
    memctl_pkg::snes_addr_t a;
    memctl_pkg::snes_addr_t byte_addr;
    memctl_pkg::word_t      d;
    e0 = errors;
    for (n = 0; n < LOOPS; n++) begin
      a     = memctl_pkg::snes_addr_t'($urandom);
      a[15] = 1'b1;
      d     = memctl_pkg::word_t'($urandom);
      byte_addr = {2'b00, a[22:16], a[14:0]} & rom_mask;
      @(posedge clk2);
      mapper      <= memctl_pkg::LOROM;
      snes_addr   <= a;
      rom_data_in <= d;
      snes_cs     <= 1'b0;
      snes_read   <= 1'b0;
      cpu_cycle();
      check_rom_addr("lorom_read rom_addr", byte_addr[23:1],
                     addr_log[SLOT0_IDX + `MEMCTL_STRB_SNES_RD]);
      check_bit("lorom_read databus_oe", 1'b0, dboe_log[SLOT0_IDX + `MEMCTL_STRB_SNES_RD]);
      check_byte("lorom_read snes_data_out", a[0] ? d[7:0] : d[15:8], snes_data_out);
    end
    @(posedge clk2);
    snes_read <= 1'b1;
    finish_test("lorom_read", e0);
  endtask

  task automatic hirom_saveram_write();
    int e0;
    int n;
    int idx;
    memctl_pkg::snes_addr_t a;
    memctl_pkg::snes_addr_t byte_addr;
    memctl_pkg::byte_t      b;
    e0 = errors;
    // Last console slot, write byte already latched
    idx = SLOT0_IDX + `MEMCTL_SNES_LAST;
    for (n = 0; n < LOOPS; n++) begin
      a        = memctl_pkg::snes_addr_t'($urandom);
      a[22:21] = 2'b01;
      a[15:13] = 3'b011;
      b        = memctl_pkg::byte_t'($urandom);
      byte_addr = `MEMCTL_SAVERAM_BASE + ({6'd0, a[20:16], a[12:0]} & saveram_mask);
      @(posedge clk2);
      mapper       <= memctl_pkg::HIROM;
      snes_addr    <= a;
      snes_data_in <= b;
      snes_write   <= 1'b0;
      cpu_cycle();
      check_rom_addr("hirom_saveram_write rom_addr", byte_addr[23:1], addr_log[idx]);
      check_bit("hirom_saveram_write rom_we", 1'b0, we_log[idx]);
      check_word("hirom_saveram_write rom_data_out", {b, b}, dout_log[idx]);
      check_bit("hirom_saveram_write rom_bhe", byte_addr[0], bhe_log[idx]);
      check_bit("hirom_saveram_write rom_ble", ~byte_addr[0], ble_log[idx]);
    end
    @(posedge clk2);
    snes_write <= 1'b1;
    finish_test("hirom_saveram_write", e0);
  endtask

  task automatic rom_write_protect();
    int   e0;
    int   n;
    int   i;
    logic we_high;
    memctl_pkg::snes_addr_t a;
    e0 = errors;
    for (n = 0; n < LOOPS; n++) begin
      a       = memctl_pkg::snes_addr_t'($urandom);
      a[15]   = 1'b1;
      we_high = 1'b1;
      @(posedge clk2);
      mapper       <= memctl_pkg::LOROM;
      snes_addr    <= a;
      snes_data_in <= memctl_pkg::byte_t'($urandom);
      snes_write   <= 1'b0;
      cpu_cycle();
      for (i = 0; i < HIGH_LEN; i++) begin
        we_high = we_high & we_log[i];
      end
      check_bit("rom_write_protect rom_we high", 1'b1, we_high);
    end
    @(posedge clk2);
    snes_write <= 1'b1;
    finish_test("rom_write_protect", e0);
  endtask

  task automatic mcu_read_share();
    int e0;
    int n;
    memctl_pkg::snes_addr_t a;
    memctl_pkg::snes_addr_t m;
    memctl_pkg::word_t      d;
    e0 = errors;
    for (n = 0; n < LOOPS; n++) begin
      a     = memctl_pkg::snes_addr_t'($urandom);
      a[15] = 1'b1;
      m     = memctl_pkg::snes_addr_t'($urandom);
      d     = memctl_pkg::word_t'($urandom);
      @(posedge clk2);
      mapper      <= memctl_pkg::LOROM;
      snes_addr   <= a;
      mcu_addr    <= m;
      rom_data_in <= d;
      snes_read   <= 1'b0;
      mcu_write   <= 1'b1;
      mcu_read    <= 1'b0;
      cpu_cycle();
      check_rom_addr("mcu_read_share first mcu slot", m[23:1], addr_log[MCU_IDX]);
      check_rom_addr("mcu_read_share last mcu slot", m[23:1], addr_log[LAST_IDX]);
      check_byte("mcu_read_share mcu_data_out", m[0] ? d[7:0] : d[15:8], mcu_data_out);
    end
    @(posedge clk2);
    snes_read <= 1'b1;
    mcu_read  <= 1'b1;
    finish_test("mcu_read_share", e0);
  endtask

  task automatic mcu_override();
    int   e0;
    int   n;
    logic w;
    logic r;
    memctl_pkg::snes_addr_t m;
    memctl_pkg::byte_t      b;
    e0 = errors;
    for (n = 0; n < LOOPS; n++) begin
      w = n[0];
      r = !n[0] | n[1];
      m = memctl_pkg::snes_addr_t'($urandom);
      b = memctl_pkg::byte_t'($urandom);
      @(posedge clk2);
      mcu_ovr     <= 1'b0;
      mcu_write   <= w;
      mcu_read    <= r;
      mcu_addr    <= m;
      mcu_data_in <= b;
      @(negedge clk2);
      check_bit("mcu_override rom_we", w, rom_we);
      check_bit("mcu_override rom_oe", r, rom_oe);
      check_rom_addr("mcu_override rom_addr", m[23:1], rom_addr);
      if (!w) begin
        check_word("mcu_override rom_data_out", {b, b}, rom_data_out);
      end
    end
    @(posedge clk2);
    mcu_ovr   <= 1'b1;
    mcu_write <= 1'b1;
    mcu_read  <= 1'b1;
    finish_test("mcu_override", e0);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'hf4cb));
    rst_n        = 1'b0;
    snes_addr    = '0;
    snes_read    = 1'b1;
    snes_write   = 1'b1;
    snes_cs      = 1'b1;
    snes_cpu_clk = 1'b1;
    snes_data_in = '0;
    mcu_ovr      = 1'b1;
    mcu_read     = 1'b1;
    mcu_write    = 1'b1;
    mcu_addr     = '0;
    mcu_data_in  = '0;
    mapper       = memctl_pkg::LOROM;
    rom_mask     = 24'h1FFFFF;
    saveram_mask = 24'h00FFFF;
    rom_data_in  = '0;
    repeat (3) @(posedge clk2);
    rst_n <= 1'b1;

    reset_idle();
    lorom_read();
    hirom_saveram_write();
    rom_write_protect();
    mcu_read_share();
    mcu_override();

    repeat (2) @(posedge clk2);
    if (i_memctl_top.i_memctl_assert.fail_count != 0) begin
      $display("Bound assertions failed %0d times", i_memctl_top.i_memctl_assert.fail_count);
      errors += i_memctl_top.i_memctl_assert.fail_count;
    end
    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
